//--- draw_background.sv
/*
 * Background stage. Paints a white one-pixel border around the visible
 * area, fills the rest with bg_color and registers the timing once.
 */
`timescale 1ns/1ps
`default_nettype none

module draw_background #(
    parameter logic [vga_pkg::cnt_w-1:0] h_active = vga_pkg::def_h_active,
    parameter logic [vga_pkg::cnt_w-1:0] v_active = vga_pkg::def_v_active
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [vga_pkg::cnt_w-1:0] hcount_in,
    input  logic [vga_pkg::cnt_w-1:0] vcount_in,
    input  logic                      hsync_in,
    input  logic                      vsync_in,
    input  logic                      hblnk_in,
    input  logic                      vblnk_in,
    input  logic [vga_pkg::rgb_w-1:0] bg_color,
    output logic [vga_pkg::cnt_w-1:0] hcount,
    output logic [vga_pkg::cnt_w-1:0] vcount,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      hblnk,
    output logic                      vblnk,
    output logic [vga_pkg::rgb_w-1:0] rgb
);

    import vga_pkg::*;

    logic [rgb_w-1:0] rgb_nxt;
    logic             on_border;

    assign on_border = (vcount_in == '0) || (vcount_in == v_active - 1'b1) ||
                       (hcount_in == '0) || (hcount_in == h_active - 1'b1);

    always_comb begin
        if (hblnk_in || vblnk_in) begin
            rgb_nxt = '0;  // black during blanking.
        end else if (on_border) begin
            rgb_nxt = color_white;
        end else begin
            rgb_nxt = bg_color;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            {hcount, vcount, hsync, vsync, hblnk, vblnk} <= '0;
            rgb <= '0;
        end else begin
            {hcount, vcount, hsync, vsync, hblnk, vblnk} <=
                {hcount_in, vcount_in, hsync_in, vsync_in, hblnk_in, vblnk_in};
            rgb <= rgb_nxt;
        end
    end

endmodule

`default_nettype wire

//--- draw_image.sv
/*
 * Image overlay stage. Decodes the 3x3 tile grid and the person sprite,
 * addresses the image ROM and selects the pixel colour, three cycles deep.
 */
`timescale 1ns/1ps
`default_nettype none

module draw_image #(
    parameter int tile_bits = vga_pkg::def_tile_bits
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [vga_pkg::cnt_w-1:0]     hcount_in,
    input  logic [vga_pkg::cnt_w-1:0]     vcount_in,
    input  logic                          hsync_in,
    input  logic                          vsync_in,
    input  logic                          hblnk_in,
    input  logic                          vblnk_in,
    input  logic [vga_pkg::rgb_w-1:0]     rgb_in,
    input  logic [vga_pkg::cnt_w-1:0]     person_x,
    input  logic [vga_pkg::cnt_w-1:0]     person_y,
    input  logic [vga_pkg::rgb_w-1:0]     rom_rgb,
    output logic [2*tile_bits-1:0]        pixel_addr,
    output logic [vga_pkg::img_sel_w-1:0] img_sel,
    output logic [vga_pkg::cnt_w-1:0]     hcount,
    output logic [vga_pkg::cnt_w-1:0]     vcount,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          hblnk,
    output logic                          vblnk,
    output logic [vga_pkg::rgb_w-1:0]     rgb
);

    import vga_pkg::*;

    localparam logic [cnt_w-1:0] tile_side = cnt_w'(1 << tile_bits);
    localparam int pipe_w = 2 * cnt_w + 5 + rgb_w;  // counters, strobes, covered, rgb.

    logic [cnt_w-1:0]     person_x_q;
    logic [cnt_w-1:0]     person_y_q;
    logic [cnt_w-1:0]     sprite_x;
    logic [cnt_w-1:0]     sprite_y;
    logic [cnt_w-1:0]     tile_x;
    logic [cnt_w-1:0]     tile_y;
    logic [cnt_w-1:0]     off_x;
    logic [cnt_w-1:0]     off_y;
    logic                 frame_start;
    logic                 hit_nxt;
    logic [img_sel_w-1:0] sel_nxt;

    logic [pipe_w-1:0]    pipe_1;
    logic [pipe_w-1:0]    pipe_2;
    logic [2*cnt_w+3:0]   timing_2;
    logic                 hit_2;
    logic [rgb_w-1:0]     rgb_2;

    function automatic logic covers(input logic [cnt_w-1:0] pos, input logic [cnt_w-1:0] start);
        return (pos >= start) && (pos - start < tile_side);
    endfunction

    // ####################
    // stage 1: decode
    // ####################
    // the new position already counts for the first pixel of the frame.
    assign frame_start = (hcount_in == '0) && (vcount_in == '0);
    assign sprite_x    = frame_start ? person_x : person_x_q;
    assign sprite_y    = frame_start ? person_y : person_y_q;

    always_comb begin
        hit_nxt = 1'b0;
        sel_nxt = '0;
        off_x   = '0;
        off_y   = '0;
        tile_x  = '0;
        tile_y  = '0;
        for (int r = 0; r < grid_n; r++) begin
            for (int c = 0; c < grid_n; c++) begin
                tile_x = cnt_w'(grid_x0 + c * tile_pitch);
                tile_y = cnt_w'(grid_y0 + r * tile_pitch);
                if (!hit_nxt && covers(hcount_in, tile_x) && covers(vcount_in, tile_y)) begin
                    hit_nxt = 1'b1;
                    sel_nxt = img_sel_w'(r * grid_n + c);  // row-major tile index.
                    off_x   = hcount_in - tile_x;
                    off_y   = vcount_in - tile_y;
                end
            end
        end
        if (!hit_nxt && covers(hcount_in, sprite_x) && covers(vcount_in, sprite_y)) begin
            hit_nxt = 1'b1;  // grid wins over the sprite.
            sel_nxt = sprite_sel;
            off_x   = hcount_in - sprite_x;
            off_y   = vcount_in - sprite_y;
        end
        if (hblnk_in || vblnk_in) begin
            hit_nxt = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        pixel_addr <= {off_y[tile_bits-1:0], off_x[tile_bits-1:0]};
        img_sel    <= sel_nxt;
    end

    // ####################
    // stages 2 and 3
    // ####################
    assign {timing_2, hit_2, rgb_2} = pipe_2;

    always_ff @(posedge clk) begin
        if (rst) begin
            person_x_q <= '0;
            person_y_q <= '0;
            pipe_1     <= '0;
            pipe_2     <= '0;
            {hcount, vcount, hsync, vsync, hblnk, vblnk} <= '0;
            rgb        <= '0;
        end else begin
            if (frame_start) begin
                person_x_q <= person_x;
                person_y_q <= person_y;
            end
            pipe_1 <= {hcount_in, vcount_in, hsync_in, vsync_in, hblnk_in, vblnk_in,
                       hit_nxt, rgb_in};
            pipe_2 <= pipe_1;  // rom word arrives with this stage.
            {hcount, vcount, hsync, vsync, hblnk, vblnk} <= timing_2;
            rgb <= hit_2 ? rom_rgb : rgb_2;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the VGA picture generator testbench with Verilator and runs it.
# The exit status of the simulation is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tb_vga_top \
    -f sources.f \
    -o sim_vga

./obj_dir/sim_vga

//--- sources.f
vga_pkg.sv
vga_timing.sv
draw_background.sv
tile_rom.sv
draw_image.sv
vga_top.sv
tb_vga_top.sv

//--- tb_vga_top.sv
/*
 * Testbench for the VGA picture generator. Drives random background
 * colours and sprite positions and checks every output pixel against a model.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vga_top;

    import vga_pkg::*;

    // ####################
    // frame and run setup
    // ####################
    localparam int h_active       = 64;
    localparam int h_total        = 80;
    localparam int h_sync_start   = 68;
    localparam int h_sync_len     = 6;
    localparam int v_active       = 60;
    localparam int v_total        = 66;
    localparam int v_sync_start   = 62;
    localparam int v_sync_len     = 2;
    localparam int tile_bits      = 4;
    localparam int tile_side      = 1 << tile_bits;
    localparam int sprite_index   = 9;
    localparam int person_x_range = 70;
    localparam int person_y_range = 62;

    localparam int clk_period      = 100;
    localparam int rst_cycles      = 8;
    localparam int latency         = 4;  // timing counter to top output.
    localparam int frame_cycles    = h_total * v_total;
    localparam int run_frames      = 12;
    localparam int watchdog_frames = 14;
    localparam int unsigned seed   = 32'he147_346e;

    logic             clk = 1'b0;
    logic             rst;
    logic [rgb_w-1:0] bg_color;
    logic [cnt_w-1:0] person_x;
    logic [cnt_w-1:0] person_y;
    logic [cnt_w-1:0] hcount;
    logic [cnt_w-1:0] vcount;
    logic             hsync;
    logic             vsync;
    logic             hblnk;
    logic             vblnk;
    logic [rgb_w-1:0] rgb;

    logic [rgb_w-1:0] next_bg;  // drawn values, shown from the next frame.
    logic [rgb_w-1:0] cur_bg;
    int               next_px;
    int               next_py;
    int               cur_px;
    int               cur_py;
    int               prev_h;
    int               prev_v;
    int               exp_h;
    int               exp_v;
    int               cyc;

    vga_top #(
        .h_active(cnt_w'(h_active)), .h_total(cnt_w'(h_total)),
        .h_sync_start(cnt_w'(h_sync_start)), .h_sync_len(cnt_w'(h_sync_len)),
        .v_active(cnt_w'(v_active)), .v_total(cnt_w'(v_total)),
        .v_sync_start(cnt_w'(v_sync_start)), .v_sync_len(cnt_w'(v_sync_len)),
        .tile_bits(tile_bits)
    ) vga_top_i (
        .clk, .rst, .bg_color, .person_x, .person_y,
        .hcount, .vcount, .hsync, .vsync, .hblnk, .vblnk, .rgb
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: time %0t, signal %s, actual %0h, expected %0h",
                     $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_outputs_zero();
        check_value("hcount", 32'(hcount), 32'd0);
        check_value("vcount", 32'(vcount), 32'd0);
        check_value("hsync", 32'(hsync), 32'd0);
        check_value("vsync", 32'(vsync), 32'd0);
        check_value("hblnk", 32'(hblnk), 32'd0);
        check_value("vblnk", 32'(vblnk), 32'd0);
        check_value("rgb", 32'(rgb), 32'd0);
    endtask

    task automatic pick_frame_inputs();
        next_bg = rgb_w'($urandom);
        next_px = int'($urandom % person_x_range);
        next_py = int'($urandom % person_y_range);
    endtask

    // ####################
    // reference model
    // ####################
    function automatic logic within_square(input int pos, input int start);
        return (pos >= start) && (pos < start + tile_side);
    endfunction

    // red holds the image, green the row and blue the column.
    function automatic logic [rgb_w-1:0] pattern_color(input int idx, input int row,
                                                       input int col);
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
        red   = 4'(idx);
        green = 4'(row);
        blue  = 4'(col);
        return {red, green, blue};
    endfunction

    function automatic logic [rgb_w-1:0] expected_rgb(input int x, input int y);
        logic [rgb_w-1:0] color;
        logic             hit;
        int               tx;
        int               ty;
        hit   = 1'b0;
        color = cur_bg;
        if (x == 0 || y == 0 || x == h_active - 1 || y == v_active - 1) begin
            color = color_white;
        end
        for (int r = 0; r < grid_n; r++) begin
            for (int c = 0; c < grid_n; c++) begin
                tx = grid_x0 + c * tile_pitch;
                ty = grid_y0 + r * tile_pitch;
                if (!hit && within_square(x, tx) && within_square(y, ty)) begin
                    hit   = 1'b1;
                    color = pattern_color(r * grid_n + c, y - ty, x - tx);
                end
            end
        end
        if (!hit && within_square(x, cur_px) && within_square(y, cur_py)) begin
            color = pattern_color(sprite_index, y - cur_py, x - cur_px);  // under the grid.
        end
        if (x >= h_active || y >= v_active) begin
            color = '0;
        end
        return color;
    endfunction

    // ####################
    // stimulus and checks
    // ####################
    initial begin
        void'($urandom(seed));
        pick_frame_inputs();
        rst      <= 1'b1;
        bg_color <= next_bg;
        person_x <= cnt_w'(next_px);
        person_y <= cnt_w'(next_py);
        prev_h = h_total - 1;  // so the first expected pixel is (0,0).
        prev_v = v_total - 1;

        @(posedge clk);
        for (int i = 1; i < rst_cycles; i++) begin
            @(posedge clk);
            check_outputs_zero();
        end
        rst <= 1'b0;
        repeat (latency) begin
            @(posedge clk);
            check_outputs_zero();  // reset state still draining.
        end

        for (cyc = 0; cyc < run_frames * frame_cycles; cyc++) begin
            @(posedge clk);
            exp_h = (prev_h == h_total - 1) ? 0 : prev_h + 1;
            exp_v = prev_v;
            if (prev_h == h_total - 1) begin
                exp_v = (prev_v == v_total - 1) ? 0 : prev_v + 1;
            end
            if (exp_h == 0 && exp_v == 0) begin
                cur_bg = next_bg;
                cur_px = next_px;
                cur_py = next_py;
            end
            check_value("hcount", 32'(hcount), 32'(exp_h));
            check_value("vcount", 32'(vcount), 32'(exp_v));
            check_value("hsync", 32'(hsync),
                        32'(exp_h >= h_sync_start && exp_h < h_sync_start + h_sync_len));
            check_value("vsync", 32'(vsync),
                        32'(exp_v >= v_sync_start && exp_v < v_sync_start + v_sync_len));
            check_value("hblnk", 32'(hblnk), 32'(exp_h >= h_active));
            check_value("vblnk", 32'(vblnk), 32'(exp_v >= v_active));
            check_value("rgb", 32'(rgb), 32'(expected_rgb(exp_h, exp_v)));
            if (exp_h == 0 && exp_v == v_active) begin
                pick_frame_inputs();  // new frame values during vertical blanking.
                bg_color <= next_bg;
                person_x <= cnt_w'(next_px);
                person_y <= cnt_w'(next_py);
            end
            prev_h = exp_h;
            prev_v = exp_v;
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(watchdog_frames * frame_cycles * clk_period);
        $display("Simulation hung and did not finish within %0d frames", watchdog_frames);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

//--- tile_rom.sv
/*
 * Image ROM. Ten images of 2^(2*tile_bits) words each, filled from the
 * package pattern, with a registered read.
 */
`timescale 1ns/1ps
`default_nettype none

module tile_rom #(
    parameter int tile_bits = vga_pkg::def_tile_bits
) (
    input  logic                          clk,
    input  logic [vga_pkg::img_sel_w-1:0] img_sel,
    input  logic [2*tile_bits-1:0]        pixel_addr,
    output logic [vga_pkg::rgb_w-1:0]     rom_rgb
);

    import vga_pkg::*;

    localparam int img_words = 1 << (2 * tile_bits);

    logic [rgb_w-1:0] mem [img_count * img_words];

    initial begin
        for (int i = 0; i < img_count; i++) begin
            for (int a = 0; a < img_words; a++) begin
                mem[i * img_words + a] = image_pattern(img_sel_w'(i), a, tile_bits);
            end
        end
    end

    // image index selects the block, pixel address the word inside it.
    always_ff @(posedge clk) begin
        rom_rgb <= mem[{img_sel, pixel_addr}];
    end

endmodule

`default_nettype wire

//--- vga_pkg.sv
/*
 * Shared definitions for the VGA picture generator. Colour and counter
 * widths, grid and sprite geometry, default frame timing and the pattern
 * that fills the image ROM.
 */
`default_nettype none

package vga_pkg;

    localparam int rgb_w     = 12;  // 4 bits each for red, green and blue.
    localparam int cnt_w     = 11;
    localparam int img_sel_w = 4;
    localparam int img_count = 10;  // nine tiles and the sprite.

    localparam logic [rgb_w-1:0] color_white = 12'hfff;

    // ####################
    // tile grid and sprite
    // ####################
    localparam int grid_n     = 3;
    localparam int grid_x0    = 4;
    localparam int grid_y0    = 2;
    localparam int tile_pitch = 18;

    localparam logic [img_sel_w-1:0] sprite_sel = 4'd9;

    // ####################
    // default frame timing
    // ####################
    localparam logic [cnt_w-1:0] def_h_active     = 11'd64;
    localparam logic [cnt_w-1:0] def_h_total      = 11'd80;
    localparam logic [cnt_w-1:0] def_h_sync_start = 11'd68;
    localparam logic [cnt_w-1:0] def_h_sync_len   = 11'd6;
    localparam logic [cnt_w-1:0] def_v_active     = 11'd60;
    localparam logic [cnt_w-1:0] def_v_total      = 11'd66;
    localparam logic [cnt_w-1:0] def_v_sync_start = 11'd62;
    localparam logic [cnt_w-1:0] def_v_sync_len   = 11'd2;
    localparam int               def_tile_bits    = 4;

    // red is the image index, green the row, blue the column.
    function automatic logic [rgb_w-1:0] image_pattern(input logic [img_sel_w-1:0] img,
                                                       input int addr, input int side_bits);
        int row;
        int col;
        row = addr >> side_bits;
        col = addr & ((1 << side_bits) - 1);
        return {img, 4'(row), 4'(col)};  // row and column wrap modulo 16.
    endfunction

endpackage

`default_nettype wire

//--- vga_timing.sv
/*
 * VGA timing generator. Frame counters with registered sync and
 * blank strobes derived from the geometry parameters.
 */
`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter logic [vga_pkg::cnt_w-1:0] h_active     = vga_pkg::def_h_active,
    parameter logic [vga_pkg::cnt_w-1:0] h_total      = vga_pkg::def_h_total,
    parameter logic [vga_pkg::cnt_w-1:0] h_sync_start = vga_pkg::def_h_sync_start,
    parameter logic [vga_pkg::cnt_w-1:0] h_sync_len   = vga_pkg::def_h_sync_len,
    parameter logic [vga_pkg::cnt_w-1:0] v_active     = vga_pkg::def_v_active,
    parameter logic [vga_pkg::cnt_w-1:0] v_total      = vga_pkg::def_v_total,
    parameter logic [vga_pkg::cnt_w-1:0] v_sync_start = vga_pkg::def_v_sync_start,
    parameter logic [vga_pkg::cnt_w-1:0] v_sync_len   = vga_pkg::def_v_sync_len
) (
    input  logic                      clk,
    input  logic                      rst,
    output logic [vga_pkg::cnt_w-1:0] hcount,
    output logic [vga_pkg::cnt_w-1:0] vcount,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      hblnk,
    output logic                      vblnk
);

    import vga_pkg::*;

    logic [cnt_w-1:0] hcount_nxt;
    logic [cnt_w-1:0] vcount_nxt;

    always_comb begin
        if (hcount == h_total - 1'b1) begin
            hcount_nxt = '0;
            if (vcount == v_total - 1'b1) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + 1'b1;  // new line.
            end
        end else begin
            hcount_nxt = hcount + 1'b1;
            vcount_nxt = vcount;
        end
    end

    // strobes are decoded from the next count so they stay aligned.
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hblnk  <= (hcount_nxt >= h_active);
            vblnk  <= (vcount_nxt >= v_active);
            hsync  <= (hcount_nxt >= h_sync_start) &&
                      (hcount_nxt < h_sync_start + h_sync_len);
            vsync  <= (vcount_nxt >= v_sync_start) &&
                      (vcount_nxt < v_sync_start + v_sync_len);
        end
    end

endmodule

`default_nettype wire

//--- vga_top.sv
/*
 * VGA picture generator top. Timing, background, image overlay and
 * image ROM in a chain, four cycles from counter to output.
 */
`timescale 1ns/1ps
`default_nettype none

module vga_top #(
    parameter logic [vga_pkg::cnt_w-1:0] h_active     = vga_pkg::def_h_active,
    parameter logic [vga_pkg::cnt_w-1:0] h_total      = vga_pkg::def_h_total,
    parameter logic [vga_pkg::cnt_w-1:0] h_sync_start = vga_pkg::def_h_sync_start,
    parameter logic [vga_pkg::cnt_w-1:0] h_sync_len   = vga_pkg::def_h_sync_len,
    parameter logic [vga_pkg::cnt_w-1:0] v_active     = vga_pkg::def_v_active,
    parameter logic [vga_pkg::cnt_w-1:0] v_total      = vga_pkg::def_v_total,
    parameter logic [vga_pkg::cnt_w-1:0] v_sync_start = vga_pkg::def_v_sync_start,
    parameter logic [vga_pkg::cnt_w-1:0] v_sync_len   = vga_pkg::def_v_sync_len,
    parameter int                        tile_bits    = vga_pkg::def_tile_bits
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [vga_pkg::rgb_w-1:0] bg_color,
    input  logic [vga_pkg::cnt_w-1:0] person_x,
    input  logic [vga_pkg::cnt_w-1:0] person_y,
    output logic [vga_pkg::cnt_w-1:0] hcount,
    output logic [vga_pkg::cnt_w-1:0] vcount,
    output logic                      hsync,
    output logic                      vsync,
    output logic                      hblnk,
    output logic                      vblnk,
    output logic [vga_pkg::rgb_w-1:0] rgb
);

    import vga_pkg::*;

    logic [cnt_w-1:0]     tim_hcount;
    logic [cnt_w-1:0]     tim_vcount;
    logic                 tim_hsync;
    logic                 tim_vsync;
    logic                 tim_hblnk;
    logic                 tim_vblnk;
    logic [cnt_w-1:0]     bg_hcount;
    logic [cnt_w-1:0]     bg_vcount;
    logic                 bg_hsync;
    logic                 bg_vsync;
    logic                 bg_hblnk;
    logic                 bg_vblnk;
    logic [rgb_w-1:0]     bg_rgb;
    logic [2*tile_bits-1:0] pixel_addr;
    logic [img_sel_w-1:0] img_sel;
    logic [rgb_w-1:0]     rom_rgb;

    vga_timing #(
        .h_active(h_active), .h_total(h_total),
        .h_sync_start(h_sync_start), .h_sync_len(h_sync_len),
        .v_active(v_active), .v_total(v_total),
        .v_sync_start(v_sync_start), .v_sync_len(v_sync_len)
    ) vga_timing_i (
        .clk, .rst,
        .hcount(tim_hcount), .vcount(tim_vcount),
        .hsync(tim_hsync), .vsync(tim_vsync),
        .hblnk(tim_hblnk), .vblnk(tim_vblnk)
    );

    draw_background #(
        .h_active(h_active), .v_active(v_active)
    ) draw_background_i (
        .clk, .rst,
        .hcount_in(tim_hcount), .vcount_in(tim_vcount),
        .hsync_in(tim_hsync), .vsync_in(tim_vsync),
        .hblnk_in(tim_hblnk), .vblnk_in(tim_vblnk),
        .bg_color,
        .hcount(bg_hcount), .vcount(bg_vcount),
        .hsync(bg_hsync), .vsync(bg_vsync),
        .hblnk(bg_hblnk), .vblnk(bg_vblnk),
        .rgb(bg_rgb)
    );

    draw_image #(
        .tile_bits(tile_bits)
    ) draw_image_i (
        .clk, .rst,
        .hcount_in(bg_hcount), .vcount_in(bg_vcount),
        .hsync_in(bg_hsync), .vsync_in(bg_vsync),
        .hblnk_in(bg_hblnk), .vblnk_in(bg_vblnk),
        .rgb_in(bg_rgb),
        .person_x, .person_y,
        .rom_rgb, .pixel_addr, .img_sel,
        .hcount, .vcount, .hsync, .vsync, .hblnk, .vblnk, .rgb
    );

    tile_rom #(
        .tile_bits(tile_bits)
    ) tile_rom_i (
        .clk, .img_sel, .pixel_addr, .rom_rgb
    );

endmodule

`default_nettype wire
